// File: vlog.f
design/mips_pkg.sv
design/instruction_decoder.sv
design/register_file.sv
design/hazard_unit.sv
design/pipe_register.sv
design/execute_stage.sv
design/mips_decode_execute.sv
verif/tb_mips_decode_execute.sv

// File: Makefile
VERILATOR = verilator
FLAGS = --binary --timing --assert -j 0
TOP = tb_mips_decode_execute
FILELIST = vlog.f
BUILD_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(BUILD_DIR)

// File: verif/tb_mips_decode_execute.sv
module tb_mips_decode_execute
	import mips_pkg::*;
();

	localparam int test_cycles = 200;

	typedef struct packed {
		ex_mem_t em;
		logic full; // every field is compared, as for a bubble
		logic jump;
		logic [31:0] target;
		logic lw;
		logic [4:0] rt;
	} stage_t;

	logic clk;
	logic reset;
	logic flush;
	logic [31:0] instr;
	logic [31:0] pc_plus_four;
	writeback_t wb;
	logic stall;
	logic redirect;
	logic halt;
	logic [31:0] redirect_target;
	ex_mem_t ex_mem;

	integer seed = 22071;
	int test_errors = 0;
	int pass_count = 0;
	int fail_count = 0;
	logic [31:0] regs [register_count];
	logic [31:0] hi_model;
	logic [31:0] lo_model;
	logic [31:0] pc;
	stage_t s1; // models id_ex
	stage_t s2; // models ex_mem
	stage_t next_s1;

	mips_decode_execute dut0 (
		.clk(clk),
		.reset(reset),
		.flush(flush),
		.instr(instr),
		.pc_plus_four(pc_plus_four),
		.wb(wb),
		.stall(stall),
		.redirect(redirect),
		.halt(halt),
		.redirect_target(redirect_target),
		.ex_mem(ex_mem)
	);

	always #20 clk = ~clk;

	function automatic logic [31:0] load_word(input logic [31:0] addr);
		return addr ^ 32'h5a5a_0f0f; // data memory stand-in
	endfunction

	// the model's result comes back as the writeback while it sits in ex_mem
	always @(posedge clk) begin
		#2;
		wb.write = s2.em.register_write;
		wb.dest = s2.em.dest;
		wb.data = s2.lw ? load_word(s2.em.alu_result) : s2.em.alu_result;
	end

	always @(posedge clk or posedge reset) begin
		if (reset) begin
			s1 <= '0;
			s2 <= '0;
		end else begin
			s2 <= s1;
			s1 <= next_s1;
		end
	end

	function automatic logic [31:0] rtype(input logic [5:0] fn, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] sa);
		return {op_rtype, rs, rt, rd, sa, fn};
	endfunction

	function automatic logic [31:0] itype(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [4:0] pick_reg();
		logic [31:0] v;
		v = $random(seed);
		return {2'b0, v[2:0]} + 5'd1;
	endfunction

	task automatic compare(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (expected === actual) else begin
			$display("ERROR at %0t: %s expected %h got %h", $time, name, expected, actual);
			test_errors++;
		end
	endtask

	// architectural model, run once per accepted instruction
	task automatic model_exec(input logic [31:0] word, output stage_t s);
		logic [4:0] rs;
		logic [4:0] rt;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] r;
		logic [63:0] p;
		rs = word[25:21];
		rt = word[20:16];
		a = regs[rs];
		b = regs[rt];
		imm = {{16{word[15]}}, word[15:0]};
		r = '0;
		s = '0;
		s.rt = rt;
		s.em.dest = rt;
		s.em.store_data = b;
		case (word[31:26])
			op_rtype: begin
				s.em.dest = word[15:11];
				s.em.register_write = 1'b1;
				case (word[5:0])
					fn_add: r = a + b;
					fn_sub: r = a - b;
					fn_and: r = a & b;
					fn_or: r = a | b;
					fn_slt: r = {31'b0, $signed(a) < $signed(b)};
					fn_sll: r = b << word[10:6];
					fn_srl: r = b >> word[10:6];
					fn_mfhi: r = hi_model;
					fn_mflo: r = lo_model;
					fn_mult: begin
						p = {{32{a[31]}}, a} * {{32{b[31]}}, b};
						hi_model = p[63:32];
						lo_model = p[31:0];
						s.em.register_write = 1'b0;
					end
					default: s.em.register_write = 1'b0;
				endcase
			end
			op_addi: r = a + imm;
			op_andi: r = a & {16'b0, word[15:0]};
			op_ori: r = a | {16'b0, word[15:0]};
			op_lw: begin
				r = a + imm;
				s.em.memory_to_register = 1'b1;
				s.lw = 1'b1;
			end
			op_sw: begin
				r = a + imm;
				s.em.memory_write = 1'b1;
			end
			op_j, op_jal: begin
				s.jump = 1'b1;
				s.target = {pc[31:28], word[25:0], 2'b00};
				s.em.dest = ra_index;
				r = pc; // link value
			end
			op_halt: s.em.halt = 1'b1;
			default: r = '0;
		endcase
		if (word[31:26] inside {op_addi, op_andi, op_ori, op_lw, op_jal})
			s.em.register_write = 1'b1;
		s.em.alu_result = r;
		if (s.em.register_write && s.em.dest != 5'd0)
			regs[s.em.dest] = s.lw ? load_word(r) : r;
	endtask

	task automatic check_outputs();
		compare("ex_mem.register_write", 32'(s2.em.register_write), 32'(ex_mem.register_write));
		compare("ex_mem.memory_to_register", 32'(s2.em.memory_to_register),
			32'(ex_mem.memory_to_register));
		compare("ex_mem.memory_write", 32'(s2.em.memory_write), 32'(ex_mem.memory_write));
		compare("halt", 32'(s2.em.halt), 32'(halt));
		if (s2.full || s2.em.register_write || s2.em.memory_write) begin
			compare("ex_mem.dest", 32'(s2.em.dest), 32'(ex_mem.dest));
			compare("ex_mem.alu_result", s2.em.alu_result, ex_mem.alu_result);
		end
		compare("ex_mem.store_data", s2.em.store_data, ex_mem.store_data);
		compare("redirect", 32'(s1.jump), 32'(redirect));
		if (s1.jump) compare("redirect_target", s1.target, redirect_target);
	endtask

	// presents one word, holding it for as long as stall is expected
	task automatic issue(input logic [31:0] word, input logic fl);
		stage_t s;
		logic exp_stall;
		do begin
			@(posedge clk);
			#2;
			instr = word;
			pc_plus_four = pc;
			flush = fl;
			@(negedge clk);
			exp_stall = s1.lw && (s1.rt == word[25:21] || s1.rt == word[20:16]);
			check_outputs();
			compare("stall", 32'(exp_stall), 32'(stall));
			if (exp_stall || fl) begin
				next_s1 = '0;
				next_s1.full = 1'b1;
				next_s1.em.halt = s1.em.halt; // only reset drops a halt in id_ex
			end else begin
				model_exec(word, s);
				next_s1 = s;
				pc = pc + 32'd4;
			end
		end while (exp_stall);
	endtask

	task automatic apply_reset();
		stage_t s;
		reset = 1'b1;
		instr = '0;
		flush = 1'b0;
		pc = 32'h0040_0004;
		hi_model = '0;
		lo_model = '0;
		for (int i = 0; i < register_count; i++) regs[i] = '0;
		repeat (5) @(posedge clk);
		#2;
		reset = 1'b0;
		@(negedge clk);
		check_outputs();
		compare("stall", 32'h0, 32'(stall));
		model_exec(32'h0, s); // the nop on the bus is captured next edge
		next_s1 = s;
	endtask

	task automatic end_test(input string name);
		issue(32'h0, 1'b0);
		issue(32'h0, 1'b0);
		if (test_errors == 0) pass_count++;
		else fail_count++;
		$display("test %s: %0s", name, (test_errors == 0) ? "ok" : "failed");
		test_errors = 0;
	endtask

	initial begin
		#(test_cycles * 40 + 2000);
		$display("timeout: the tests did not finish in the expected time");
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		logic [5:0] fns [5];
		logic [31:0] v;
		fns = '{fn_add, fn_sub, fn_and, fn_or, fn_slt};
		clk = 1'b0;
		wb = '0;
		pc_plus_four = '0;
		apply_reset();

		for (int i = 1; i < 8; i++) begin
			v = $random(seed);
			issue(itype(op_addi, 5'd0, 5'(i), v[15:0]), 1'b0);
		end
		issue(rtype(fn_add, 5'd1, 5'd2, 5'd3, 5'd0), 1'b0);
		issue(rtype(fn_sub, 5'd3, 5'd3, 5'd4, 5'd0), 1'b0); // needs forwarding on both sides
		for (int i = 0; i < 20; i++) begin
			v = $random(seed);
			issue(rtype(fns[v[31:0] % 5], pick_reg(), pick_reg(), pick_reg(), 5'd0), 1'b0);
		end
		end_test("alu register ops");

		for (int i = 0; i < 20; i++) begin
			v = $random(seed);
			case (i % 5)
				0: issue(itype(op_addi, pick_reg(), pick_reg(), v[15:0]), 1'b0);
				1: issue(itype(op_andi, pick_reg(), pick_reg(), v[15:0]), 1'b0);
				2: issue(itype(op_ori, pick_reg(), pick_reg(), v[15:0]), 1'b0);
				3: issue(rtype(fn_sll, 5'd0, pick_reg(), pick_reg(), v[4:0]), 1'b0);
				default: issue(rtype(fn_srl, 5'd0, pick_reg(), pick_reg(), v[4:0]), 1'b0);
			endcase
		end
		end_test("immediates and shifts");

		issue(itype(op_lw, 5'd1, 5'd8, 16'h0010), 1'b0);
		issue(rtype(fn_add, 5'd8, 5'd2, 5'd9, 5'd0), 1'b0); // load-use, one bubble
		issue(itype(op_lw, 5'd1, 5'd10, 16'hfff0), 1'b0);
		issue(rtype(fn_add, 5'd2, 5'd3, 5'd11, 5'd0), 1'b0);
		issue(rtype(fn_or, 5'd10, 5'd9, 5'd12, 5'd0), 1'b0);
		issue(itype(op_sw, 5'd1, 5'd12, 16'h0020), 1'b0); // store data comes forwarded
		end_test("load-use stall");

		issue(rtype(fn_mult, 5'd1, 5'd2, 5'd0, 5'd0), 1'b0);
		issue(rtype(fn_mfhi, 5'd0, 5'd0, 5'd12, 5'd0), 1'b0);
		issue(rtype(fn_mflo, 5'd0, 5'd0, 5'd13, 5'd0), 1'b0);
		end_test("mult and hi/lo moves");

		v = $random(seed);
		issue({op_j, v[25:0]}, 1'b0);
		v = $random(seed);
		issue({op_jal, v[25:0]}, 1'b0);
		issue(rtype(fn_add, 5'd31, 5'd0, 5'd14, 5'd0), 1'b0); // reads the link register
		end_test("jumps");

		apply_reset();
		issue(itype(op_addi, 5'd0, 5'd1, 16'h1234), 1'b1);
		issue({op_halt, 26'h0}, 1'b0);
		issue(32'h0, 1'b1);
		issue(32'h0, 1'b0);
		issue(32'h0, 1'b0); // the flushed bubble still carries the halt
		apply_reset();
		compare("halt", 32'h0, 32'(halt));
		end_test("reset, flush and halt");

		$display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// File: design/mips_decode_execute.sv
module mips_decode_execute
	import mips_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic flush,
	input logic [31:0] instr,
	input logic [31:0] pc_plus_four,
	input writeback_t wb,
	output logic stall,
	output logic redirect,
	output logic halt,
	output logic [31:0] redirect_target,
	output ex_mem_t ex_mem
);

	id_ex_t decoded;
	id_ex_t id_ex_d;
	id_ex_t id_ex;
	ex_mem_t ex_result;
	logic [31:0] src_a;
	logic [31:0] src_b;
	logic [31:0] hi;
	logic [31:0] lo;
	logic [31:0] hi_in;
	logic [31:0] lo_in;
	logic hi_write;
	logic lo_write;
	logic id_ex_clear;
	logic forward_a;
	logic forward_b;

	instruction_decoder decoder0 (
		.instr(instr),
		.pc_plus_four(pc_plus_four),
		.ctrl(decoded)
	);

	register_file regfile0 (
		.clk(clk),
		.reset(reset),
		.rs(decoded.rs),
		.rt(decoded.rt),
		.src_a(src_a),
		.src_b(src_b),
		.wb(wb),
		.hi_write(hi_write),
		.lo_write(lo_write),
		.hi_in(hi_in),
		.lo_in(lo_in),
		.hi(hi),
		.lo(lo)
	);

	always_comb begin
		id_ex_d = decoded;
		id_ex_d.src_a = src_a;
		id_ex_d.src_b = src_b;
	end

	hazard_unit hazard0 (
		.rs_decode(decoded.rs),
		.rt_decode(decoded.rt),
		.id_ex(id_ex),
		.ex_mem(ex_mem),
		.flush(flush),
		.stall(stall),
		.id_ex_clear(id_ex_clear),
		.forward_a(forward_a),
		.forward_b(forward_b)
	);

	pipe_register #(.payload_t(id_ex_t)) id_ex_reg0 (
		.clk(clk),
		.reset(reset),
		.clear(id_ex_clear), // a bubble on load-use or flush
		.d(id_ex_d),
		.q(id_ex)
	);

	execute_stage execute0 (
		.id_ex(id_ex),
		.forward_a(forward_a),
		.forward_b(forward_b),
		.forward_value(ex_mem.alu_result),
		.hi(hi),
		.lo(lo),
		.result(ex_result),
		.hi_write(hi_write),
		.lo_write(lo_write),
		.hi_in(hi_in),
		.lo_in(lo_in),
		.redirect(redirect),
		.redirect_target(redirect_target)
	);

	pipe_register #(.payload_t(ex_mem_t)) ex_mem_reg0 (
		.clk(clk),
		.reset(reset),
		.clear(1'b0),
		.d(ex_result),
		.q(ex_mem)
	);

	assign halt = ex_mem.halt;

endmodule

// File: design/execute_stage.sv
module execute_stage
	import mips_pkg::*;
(
	input id_ex_t id_ex,
	input logic forward_a,
	input logic forward_b,
	input logic [31:0] forward_value,
	input logic [31:0] hi,
	input logic [31:0] lo,
	output ex_mem_t result,
	output logic hi_write,
	output logic lo_write,
	output logic [31:0] hi_in,
	output logic [31:0] lo_in,
	output logic redirect,
	output logic [31:0] redirect_target
);

	logic [31:0] reg_a;
	logic [31:0] reg_b;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] alu_out;
	logic [63:0] product;

	assign reg_a = forward_a ? forward_value : id_ex.src_a;
	assign reg_b = forward_b ? forward_value : id_ex.src_b;
	assign a = id_ex.alu_src_a ? {27'b0, id_ex.sa} : reg_a;

	always_comb begin
		case (id_ex.alu_src_b)
			srcb_sign: b = id_ex.sign_imm;
			srcb_zero: b = {16'b0, id_ex.sign_imm[15:0]};
			default: b = reg_b;
		endcase
	end

	always_comb begin
		case (id_ex.alu_function)
			fn_sub: alu_out = a - b;
			fn_and: alu_out = a & b;
			fn_or: alu_out = a | b;
			fn_slt: alu_out = {31'b0, $signed(a) < $signed(b)};
			fn_sll: alu_out = b << a[4:0];
			fn_srl: alu_out = b >> a[4:0];
			default: alu_out = a + b;
		endcase
	end

	assign product = $signed(a) * $signed(b); // mult is signed, full 64-bit result
	assign hi_write = id_ex.hi_write;
	assign lo_write = id_ex.lo_write;
	assign hi_in = product[63:32];
	assign lo_in = product[31:0];

	always_comb begin
		result = '0;
		if (id_ex.op == op_jal) result.alu_result = id_ex.pc_plus_four; // link value
		else if (id_ex.using_hi_lo) result.alu_result = (id_ex.alu_function == fn_mfhi) ? hi : lo;
		else result.alu_result = alu_out;
		result.store_data = reg_b;
		case (id_ex.register_destination)
			dst_rd: result.dest = id_ex.rd;
			dst_ra: result.dest = ra_index;
			default: result.dest = id_ex.rt;
		endcase
		result.register_write = id_ex.register_write;
		result.memory_to_register = id_ex.memory_to_register;
		result.memory_write = id_ex.memory_write;
		result.halt = id_ex.halt;
	end

	assign redirect = id_ex.jump;
	assign redirect_target = id_ex.jump_target;

endmodule

// File: design/pipe_register.sv
module pipe_register
	import mips_pkg::*;
#(
	parameter type payload_t = ex_mem_t
) (
	input logic clk,
	input logic reset,
	input logic clear,
	input payload_t d,
	output payload_t q
);

	payload_t cleared;

	always_comb begin
		cleared = '0;
		cleared.halt = q.halt; // halt is held through a clear, only reset drops it
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset) q <= '0;
		else if (clear) q <= cleared;
		else q <= d;
	end

endmodule

// File: design/hazard_unit.sv
module hazard_unit
	import mips_pkg::*;
(
	input logic [4:0] rs_decode,
	input logic [4:0] rt_decode,
	input id_ex_t id_ex,
	input ex_mem_t ex_mem,
	input logic flush,
	output logic stall,
	output logic id_ex_clear,
	output logic forward_a,
	output logic forward_b
);

	logic ex_mem_forwardable;

	// a load in execute has no data yet, so its consumer waits one cycle
	assign stall = id_ex.memory_to_register &&
		(id_ex.rt == rs_decode || id_ex.rt == rt_decode);

	assign id_ex_clear = stall || flush;

	assign ex_mem_forwardable = ex_mem.register_write && !ex_mem.memory_to_register &&
		(ex_mem.dest != 5'd0);

	assign forward_a = ex_mem_forwardable && (ex_mem.dest == id_ex.rs);
	assign forward_b = ex_mem_forwardable && (ex_mem.dest == id_ex.rt);

endmodule

// File: design/register_file.sv
module register_file
	import mips_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic [4:0] rs,
	input logic [4:0] rt,
	output logic [31:0] src_a,
	output logic [31:0] src_b,
	input writeback_t wb,
	input logic hi_write,
	input logic lo_write,
	input logic [31:0] hi_in,
	input logic [31:0] lo_in,
	output logic [31:0] hi,
	output logic [31:0] lo
);

	logic [31:0] regs [register_count];
	logic wb_valid;

	assign wb_valid = wb.write && (wb.dest != 5'd0); // register 0 ignores writes

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			for (int i = 0; i < register_count; i++) begin
				regs[i] <= '0;
			end
			hi <= '0;
			lo <= '0;
		end else begin
			if (wb_valid) regs[wb.dest] <= wb.data;
			if (hi_write) hi <= hi_in;
			if (lo_write) lo <= lo_in;
		end
	end

	// a same-cycle writeback is visible to the decode reading it
	assign src_a = (wb_valid && wb.dest == rs) ? wb.data : regs[rs];
	assign src_b = (wb_valid && wb.dest == rt) ? wb.data : regs[rt];

endmodule

// File: design/instruction_decoder.sv
module instruction_decoder
	import mips_pkg::*;
(
	input logic [31:0] instr,
	input logic [31:0] pc_plus_four,
	output id_ex_t ctrl
);

	logic [5:0] op;
	logic [5:0] funct;

	assign op = instr[31:26];
	assign funct = instr[5:0];

	always_comb begin
		ctrl = '0; // register values are merged in by the top
		ctrl.op = op;
		ctrl.rs = instr[25:21];
		ctrl.rt = instr[20:16];
		ctrl.rd = instr[15:11];
		ctrl.sa = instr[10:6];
		ctrl.sign_imm = {{16{instr[15]}}, instr[15:0]};
		ctrl.pc_plus_four = pc_plus_four;
		ctrl.jump_target = {pc_plus_four[31:28], instr[25:0], 2'b00};
		case (op)
			op_rtype: begin
				ctrl.register_destination = dst_rd;
				ctrl.alu_function = funct;
				case (funct)
					fn_add, fn_sub, fn_and, fn_or, fn_slt: ctrl.register_write = 1'b1;
					fn_sll, fn_srl: begin
						ctrl.register_write = 1'b1;
						ctrl.alu_src_a = 1'b1; // sa is the shift amount, rt the value
					end
					fn_mult: begin
						ctrl.hi_write = 1'b1;
						ctrl.lo_write = 1'b1;
					end
					fn_mfhi, fn_mflo: begin
						ctrl.register_write = 1'b1;
						ctrl.using_hi_lo = 1'b1;
					end
					default: ctrl.register_write = 1'b0;
				endcase
			end
			op_addi, op_andi, op_ori: begin
				ctrl.register_write = 1'b1;
				ctrl.register_destination = dst_rt;
				ctrl.alu_src_b = (op == op_addi) ? srcb_sign : srcb_zero; // logical ops zero-extend
				ctrl.alu_function = (op == op_addi) ? fn_add : (op == op_andi) ? fn_and : fn_or;
			end
			op_lw: begin
				ctrl.register_write = 1'b1;
				ctrl.memory_to_register = 1'b1;
				ctrl.register_destination = dst_rt;
				ctrl.alu_src_b = srcb_sign;
				ctrl.alu_function = fn_add;
			end
			op_sw: begin
				ctrl.memory_write = 1'b1;
				ctrl.alu_src_b = srcb_sign;
				ctrl.alu_function = fn_add;
			end
			op_j: ctrl.jump = 1'b1;
			op_jal: begin
				ctrl.jump = 1'b1;
				ctrl.register_write = 1'b1;
				ctrl.register_destination = dst_ra;
			end
			op_halt: ctrl.halt = 1'b1;
			default: ctrl.jump = 1'b0;
		endcase
	end

endmodule

// File: design/mips_pkg.sv
package mips_pkg;

	localparam int register_count = 32;
	localparam logic [4:0] ra_index = 5'd31;

	localparam logic [5:0] op_rtype = 6'h00;
	localparam logic [5:0] op_j = 6'h02;
	localparam logic [5:0] op_jal = 6'h03;
	localparam logic [5:0] op_addi = 6'h08;
	localparam logic [5:0] op_andi = 6'h0c;
	localparam logic [5:0] op_ori = 6'h0d;
	localparam logic [5:0] op_lw = 6'h23;
	localparam logic [5:0] op_sw = 6'h2b;
	localparam logic [5:0] op_halt = 6'h3f;

	localparam logic [5:0] fn_sll = 6'h00;
	localparam logic [5:0] fn_srl = 6'h02;
	localparam logic [5:0] fn_mfhi = 6'h10;
	localparam logic [5:0] fn_mflo = 6'h12;
	localparam logic [5:0] fn_mult = 6'h18;
	localparam logic [5:0] fn_add = 6'h20;
	localparam logic [5:0] fn_sub = 6'h22;
	localparam logic [5:0] fn_and = 6'h24;
	localparam logic [5:0] fn_or = 6'h25;
	localparam logic [5:0] fn_slt = 6'h2a;

	// operand b sources and destination choices
	localparam logic [1:0] srcb_reg = 2'd0;
	localparam logic [1:0] srcb_sign = 2'd1;
	localparam logic [1:0] srcb_zero = 2'd2;
	localparam logic [1:0] dst_rt = 2'd0;
	localparam logic [1:0] dst_rd = 2'd1;
	localparam logic [1:0] dst_ra = 2'd2;

	typedef struct packed {
		logic register_write;
		logic memory_to_register;
		logic memory_write;
		logic alu_src_a; // shift amount replaces operand a
		logic [1:0] alu_src_b;
		logic [1:0] register_destination;
		logic hi_write;
		logic lo_write;
		logic [5:0] alu_function;
		logic jump;
		logic using_hi_lo;
		logic halt;
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] sa;
		logic [31:0] sign_imm;
		logic [31:0] src_a;
		logic [31:0] src_b;
		logic [31:0] pc_plus_four;
		logic [31:0] jump_target;
	} id_ex_t;

	typedef struct packed {
		logic [31:0] alu_result;
		logic [31:0] store_data;
		logic [4:0] dest;
		logic register_write;
		logic memory_to_register;
		logic memory_write;
		logic halt;
	} ex_mem_t;

	typedef struct packed {
		logic write;
		logic [4:0] dest;
		logic [31:0] data;
	} writeback_t;

endpackage
